//--- cache_pkg.sv
package cache_pkg;

    localparam int ADDR_WIDTH   = 16;
    localparam int WORD_WIDTH   = 32;
    localparam int BYTE_WIDTH   = 2;   // Byte select inside a word
    localparam int OFFSET_WIDTH = 2;
    localparam int INDEX_WIDTH  = 4;
    localparam int TAG_WIDTH    = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH - BYTE_WIDTH;

    localparam int LINE_NUM     = 1 << INDEX_WIDTH;
    localparam int LINE_WORDS   = 1 << OFFSET_WIDTH;
    localparam int WAY_NUM      = 4;

    // Lowest address bit above the line offset
    localparam int LINE_LSB     = BYTE_WIDTH + OFFSET_WIDTH;

    localparam int AGE_WIDTH    = 2;   // Enough to order four ways

    typedef logic [ADDR_WIDTH-1:0]              addr_t;
    typedef logic [WORD_WIDTH-1:0]              word_t;
    typedef logic [TAG_WIDTH-1:0]               tag_t;
    typedef logic [INDEX_WIDTH-1:0]             index_t;
    typedef logic [OFFSET_WIDTH-1:0]            offset_t;
    typedef logic [WAY_NUM-1:0]                 way_mask_t;
    typedef logic [AGE_WIDTH-1:0]               age_t;
    typedef logic [LINE_WORDS*WORD_WIDTH-1:0]   line_t;   // Word 0 in the low bits

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        MISS_WAIT,
        REFILL
    } ctrl_state_t;

endpackage

//--- refill_if.sv
`timescale 1ns/1ps

interface refill_if
    import cache_pkg::*;
();

    logic      en;      // Write strobe, one cycle
    tag_t      tag;
    index_t    index;
    line_t     line;
    way_mask_t way;     // Victim, one-hot

    modport ctrl (
        output en,
        output tag,
        output index,
        output line
    );

    modport tag_side (
        input  en,
        input  tag,
        input  index,
        input  line,
        output way
    );

    modport data_side (
        input  en,
        input  tag,
        input  index,
        input  line,
        input  way
    );

endinterface

//--- lru.sv
`timescale 1ns/1ps

module lru
    import cache_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      lookup,
    input  index_t    index,
    input  way_mask_t hit,
    input  way_mask_t valid,
    input  logic      refill,
    input  way_mask_t refill_way,
    output way_mask_t victim
);

    age_t      age_mem [LINE_NUM][WAY_NUM];
    way_mask_t touch;
    age_t      touch_age;
    age_t      max_age;
    logic      found_invalid;

    // Empty way first, otherwise the oldest one
    always_comb begin
        victim        = '0;
        found_invalid = 1'b0;
        max_age       = age_mem[index][0];
        for (int w = 0; w < WAY_NUM; w++) begin
            if (!valid[w] && !found_invalid) begin
                victim[w]     = 1'b1;
                found_invalid = 1'b1;
            end
        end
        if (!found_invalid) begin
            victim[0] = 1'b1;
            for (int w = 1; w < WAY_NUM; w++) begin
                if (age_mem[index][w] > max_age) begin
                    max_age   = age_mem[index][w];
                    victim    = '0;
                    victim[w] = 1'b1;
                end
            end
        end
    end

    assign touch = refill ? refill_way : ((lookup && |hit) ? hit : '0);

    always_comb begin
        touch_age = '0;
        for (int w = 0; w < WAY_NUM; w++) begin
            if (touch[w]) begin
                touch_age = age_mem[index][w];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // Ages start as a permutation so the order stays strict
            for (int s = 0; s < LINE_NUM; s++) begin
                for (int w = 0; w < WAY_NUM; w++) begin
                    age_mem[s][w] <= age_t'(w);
                end
            end
        end else if (|touch) begin
            for (int w = 0; w < WAY_NUM; w++) begin
                if (touch[w]) begin
                    age_mem[index][w] <= '0;   // Most recent
                end else if (age_mem[index][w] < touch_age) begin
                    age_mem[index][w] <= age_mem[index][w] + 1'b1;
                end
            end
        end
    end

endmodule

//--- tag_ram.sv
`timescale 1ns/1ps

module tag_ram
    import cache_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       lookup,
    input  tag_t       tag,
    input  index_t     index,
    output way_mask_t  hit,
    refill_if.tag_side rf
);

    tag_t                tag_mem   [WAY_NUM][LINE_NUM];
    logic [LINE_NUM-1:0] valid_mem [WAY_NUM];
    way_mask_t           valid;      // Valid bits of the addressed set
    way_mask_t           victim;
    way_mask_t           victim_q;

    // All four ways compared in parallel
    always_comb begin
        for (int w = 0; w < WAY_NUM; w++) begin
            valid[w] = valid_mem[w][index];
            hit[w]   = valid[w] && (tag_mem[w][index] == tag);
        end
    end

    lru u_lru (
        .clk        (clk),
        .rst_n      (rst_n),
        .lookup     (lookup),
        .index      (index),
        .hit        (hit),
        .valid      (valid),
        .refill     (rf.en),
        .refill_way (victim_q),
        .victim     (victim)
    );

    assign rf.way = victim_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            victim_q <= '0;
            for (int w = 0; w < WAY_NUM; w++) begin
                valid_mem[w] <= '0;
                for (int s = 0; s < LINE_NUM; s++) begin
                    tag_mem[w][s] <= '0;
                end
            end
        end else begin
            victim_q <= victim;   // Set index is stable through a miss
            if (rf.en) begin
                for (int w = 0; w < WAY_NUM; w++) begin
                    if (rf.way[w]) begin
                        tag_mem[w][rf.index]   <= rf.tag;
                        valid_mem[w][rf.index] <= 1'b1;
                    end
                end
            end
        end
    end

endmodule

//--- data_ram.sv
`timescale 1ns/1ps

module data_ram
    import cache_pkg::*;
(
    input  logic        clk,
    input  index_t      index,
    input  offset_t     offset,
    input  way_mask_t   hit,
    output word_t       rd_word,
    refill_if.data_side rf
);

    line_t line_mem [WAY_NUM][LINE_NUM];
    line_t sel_line;

    // Hit is one-hot, so OR-ing the masked lines selects one
    always_comb begin
        sel_line = '0;
        for (int w = 0; w < WAY_NUM; w++) begin
            if (hit[w]) begin
                sel_line = sel_line | line_mem[w][index];
            end
        end
        rd_word = sel_line[offset*WORD_WIDTH +: WORD_WIDTH];   // Zero on a miss
    end

    always_ff @(posedge clk) begin
        if (rf.en) begin
            for (int w = 0; w < WAY_NUM; w++) begin
                if (rf.way[w]) begin
                    line_mem[w][rf.index] <= rf.line;   // Whole line at once
                end
            end
        end
    end

endmodule

//--- cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl
    import cache_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      req,
    input  addr_t     addr,
    output word_t     rdata,
    output logic      rdata_valid,
    output logic      busy,
    output logic      mem_req,
    output addr_t     mem_addr,
    input  logic      mem_valid,
    input  line_t     mem_line,
    output tag_t      lu_tag,
    output index_t    lu_index,
    output offset_t   lu_offset,
    output logic      lookup,
    input  way_mask_t hit,
    input  word_t     rd_word,
    refill_if.ctrl    rf
);

    ctrl_state_t state;
    addr_t       addr_q;
    line_t       line_q;
    logic        accept;

    // Still busy in the cycle the data goes out
    assign busy   = (state != IDLE) || rdata_valid;
    assign accept = req && !busy;

    assign lu_tag    = addr_q[ADDR_WIDTH-1 -: TAG_WIDTH];
    assign lu_index  = addr_q[LINE_LSB +: INDEX_WIDTH];
    assign lu_offset = addr_q[BYTE_WIDTH +: OFFSET_WIDTH];
    assign lookup    = (state == LOOKUP);

    assign mem_addr = {addr_q[ADDR_WIDTH-1:LINE_LSB], {LINE_LSB{1'b0}}};   // Line aligned

    assign rf.en    = (state == REFILL);
    assign rf.tag   = lu_tag;
    assign rf.index = lu_index;
    assign rf.line  = line_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= IDLE;
            rdata_valid <= 1'b0;
            mem_req     <= 1'b0;
        end else begin
            rdata_valid <= 1'b0;
            mem_req     <= 1'b0;
            case (state)
                IDLE: begin
                    if (accept) begin
                        state <= LOOKUP;
                    end
                end
                LOOKUP: begin
                    if (|hit) begin
                        rdata_valid <= 1'b1;
                        state       <= IDLE;
                    end else begin
                        mem_req <= 1'b1;   // Whole line from memory
                        state   <= MISS_WAIT;
                    end
                end
                MISS_WAIT: begin
                    if (mem_valid) begin
                        state <= REFILL;
                    end
                end
                REFILL: begin
                    rdata_valid <= 1'b1;
                    state       <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Address, response line and read data
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= addr;   // Held until the miss is done
        end
        if (state == MISS_WAIT && mem_valid) begin
            line_q <= mem_line;
        end
        if (state == LOOKUP) begin
            rdata <= rd_word;
        end else if (state == REFILL) begin
            rdata <= line_q[lu_offset*WORD_WIDTH +: WORD_WIDTH];
        end
    end

endmodule

//--- cache_top.sv
`timescale 1ns/1ps

module cache_top
    import cache_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  req,
    input  addr_t addr,
    output word_t rdata,
    output logic  rdata_valid,
    output logic  busy,
    output logic  mem_req,
    output addr_t mem_addr,
    input  logic  mem_valid,
    input  line_t mem_line
);

    tag_t      lu_tag;
    index_t    lu_index;
    offset_t   lu_offset;
    logic      lookup;
    way_mask_t hit;
    word_t     rd_word;

    refill_if rf_bus ();

    cache_ctrl u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (req),
        .addr        (addr),
        .rdata       (rdata),
        .rdata_valid (rdata_valid),
        .busy        (busy),
        .mem_req     (mem_req),
        .mem_addr    (mem_addr),
        .mem_valid   (mem_valid),
        .mem_line    (mem_line),
        .lu_tag      (lu_tag),
        .lu_index    (lu_index),
        .lu_offset   (lu_offset),
        .lookup      (lookup),
        .hit         (hit),
        .rd_word     (rd_word),
        .rf          (rf_bus.ctrl)
    );

    tag_ram u_tag_ram (
        .clk    (clk),
        .rst_n  (rst_n),
        .lookup (lookup),
        .tag    (lu_tag),
        .index  (lu_index),
        .hit    (hit),
        .rf     (rf_bus.tag_side)
    );

    data_ram u_data_ram (
        .clk     (clk),
        .index   (lu_index),
        .offset  (lu_offset),
        .hit     (hit),
        .rd_word (rd_word),
        .rf      (rf_bus.data_side)
    );

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;   // 20 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;   // Released on a falling edge
    end

endmodule

//--- cache_tb.sv
`timescale 1ns/1ps

module cache_tb
    import cache_pkg::*;
();

    localparam int N_RESET     = 4;
    localparam int N_REPEAT    = 6;
    localparam int N_EVICT     = 11;
    localparam int N_RANDOM    = 200;
    localparam int N_BUSY      = 4;
    localparam int TOTAL_REQ   = N_RESET + N_REPEAT + N_EVICT + N_RANDOM + N_BUSY;
    localparam int CYCLE_LIMIT = 40 * TOTAL_REQ;
    localparam int READ_WAIT   = 30;   // Slowest miss takes about 13 cycles
    localparam int WANT_ANY    = 0;
    localparam int WANT_HIT    = 1;
    localparam int WANT_MISS   = 2;

    logic  clk;
    logic  rst_n;
    logic  req;
    addr_t addr;
    word_t rdata;
    logic  rdata_valid;
    logic  busy;
    logic  mem_req;
    addr_t mem_addr;
    logic  mem_valid;
    line_t mem_line;

    // Reference model of the tag side
    tag_t        m_tag   [LINE_NUM][WAY_NUM];
    logic        m_valid [LINE_NUM][WAY_NUM];
    int unsigned m_stamp [LINE_NUM][WAY_NUM];   // Time of last use
    int unsigned m_time;

    // What the last read looked like at the pins
    logic  seen_done;
    int    seen_rv;
    int    seen_mreq;
    int    seen_busy_low;
    logic  seen_busy_late;
    int    done_cycle;
    int    mreq_cycle;
    int    mv_cycle;
    addr_t seen_maddr;
    word_t seen_rdata;

    logic [15:0] lfsr_state;
    int          test_errs;
    int          pass_count;
    int          fail_count;
    int          cycle_count = 0;

    tb_clock_gen u_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    cache_top dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (req),
        .addr        (addr),
        .rdata       (rdata),
        .rdata_valid (rdata_valid),
        .busy        (busy),
        .mem_req     (mem_req),
        .mem_addr    (mem_addr),
        .mem_valid   (mem_valid),
        .mem_line    (mem_line)
    );

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Simulation FAILED");
            $finish;
        end
    end

    function automatic word_t mem_word(input addr_t a);
        return {a ^ 16'hA5C3, a};   // a is word aligned
    endfunction

    function automatic line_t mem_line_at(input addr_t base);
        line_t l;
        for (int w = 0; w < LINE_WORDS; w++) begin
            l[w*WORD_WIDTH +: WORD_WIDTH] = mem_word(base + addr_t'(4 * w));
        end
        return l;
    endfunction

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // One LFSR step per bit
    function automatic int take_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_step(lfsr_state);
        end
        return v;
    endfunction

    function automatic addr_t make_addr(input tag_t t, input index_t s, input offset_t o);
        return {t, s, o, {BYTE_WIDTH{1'b0}}};
    endfunction

    // Hit check, then fill of the first empty way or the least recently used one
    function automatic logic model_access(input addr_t a);
        tag_t   t;
        index_t s;
        int     way;
        logic   hit;
        t       = a[ADDR_WIDTH-1 -: TAG_WIDTH];
        s       = a[LINE_LSB +: INDEX_WIDTH];
        way     = -1;
        hit     = 1'b0;
        m_time++;
        for (int w = 0; w < WAY_NUM; w++) begin
            if (m_valid[s][w] && m_tag[s][w] == t) begin
                way = w;
                hit = 1'b1;
            end
        end
        for (int w = WAY_NUM - 1; w >= 0; w--) begin
            if (!hit && !m_valid[s][w]) begin
                way = w;
            end
        end
        if (way < 0) begin
            way = 0;
            for (int w = 1; w < WAY_NUM; w++) begin
                if (m_stamp[s][w] < m_stamp[s][way]) begin
                    way = w;
                end
            end
        end
        m_tag[s][way]   = t;
        m_valid[s][way] = 1'b1;
        m_stamp[s][way] = m_time;
        return hit;
    endfunction

    task automatic report_error(input string msg);
        $display("ERROR %0t: %s", $time, msg);
        test_errs++;
    endtask

    // Drives one read and plays the memory; poke pulses req while busy
    task automatic run_read(input addr_t a, input int lat, input logic poke,
                            input addr_t poke_addr);
        seen_done      = 1'b0;
        seen_rv        = 0;
        seen_mreq      = 0;
        seen_busy_low  = 0;
        seen_busy_late = 1'b0;
        done_cycle     = 0;
        mreq_cycle     = 0;
        mv_cycle       = 0;
        @(negedge clk);
        req  = 1'b1;
        addr = a;
        for (int n = 1; n <= READ_WAIT && !seen_done; n++) begin
            @(negedge clk);
            req       = 1'b0;
            mem_valid = 1'b0;
            if (!busy) begin
                seen_busy_low++;
            end
            if (rdata_valid) begin
                seen_rv++;
                seen_done  = 1'b1;
                done_cycle = n;
                seen_rdata = rdata;
            end
            if (mem_req) begin
                seen_mreq++;
                mreq_cycle = n;
                seen_maddr = mem_addr;
            end
            if (seen_mreq > 0 && n == mreq_cycle + lat - 1) begin
                mem_valid = 1'b1;
                mem_line  = mem_line_at(seen_maddr);
                mv_cycle  = n;
            end
            if (poke && busy) begin
                req  = 1'b1;
                addr = poke_addr;
            end
        end
        repeat (poke ? 4 : 1) begin
            @(negedge clk);
            req       = 1'b0;
            mem_valid = 1'b0;
            if (busy) begin
                seen_busy_late = 1'b1;
            end
            if (rdata_valid) begin
                seen_rv++;
            end
            if (mem_req) begin
                seen_mreq++;
            end
        end
    endtask

    task automatic check_read(input addr_t a, input int lat, input int want,
                              input logic poke, input addr_t poke_addr);
        logic  exp_hit;
        addr_t line_addr;
        word_t exp_word;
        exp_hit   = model_access(a);
        line_addr = a & ~addr_t'(4 * LINE_WORDS - 1);   // 16-byte lines
        exp_word  = mem_word({a[ADDR_WIDTH-1:BYTE_WIDTH], {BYTE_WIDTH{1'b0}}});
        if ((want == WANT_HIT && !exp_hit) || (want == WANT_MISS && exp_hit)) begin
            $display("Test setup went wrong: read of %h is not the hit or miss intended", a);
            test_errs++;
        end
        run_read(a, lat, poke, poke_addr);
        if (!seen_done) begin
            $display("Read of %h got no rdata_valid within %0d cycles", a, READ_WAIT);
            test_errs++;
        end else begin
            if (seen_rv != 1) begin
                report_error($sformatf("read %h gave %0d rdata_valid pulses", a, seen_rv));
            end
            if (seen_busy_low != 0) begin
                report_error($sformatf("read %h had busy low for %0d cycles", a, seen_busy_low));
            end
            if (seen_busy_late) begin
                report_error($sformatf("busy still high after read %h", a));
            end
            if (exp_hit) begin
                if (seen_mreq != 0) begin
                    report_error($sformatf("read %h should hit but sent mem_req", a));
                end
                if (done_cycle != 2) begin
                    report_error($sformatf("hit %h took %0d cycles", a, done_cycle));
                end
            end else if (seen_mreq != 1) begin
                report_error($sformatf("miss %h gave %0d mem_req pulses", a, seen_mreq));
            end else begin
                if (seen_maddr != line_addr) begin
                    report_error($sformatf("mem_addr %h, expected %h", seen_maddr, line_addr));
                end
                if (mreq_cycle != 2 || done_cycle != mv_cycle + 2) begin
                    report_error($sformatf("miss %h timing: mem_req at %0d, data at %0d",
                                           a, mreq_cycle, done_cycle));
                end
            end
            if (seen_rdata != exp_word) begin
                report_error($sformatf("read %h gave %h, expected %h", a, seen_rdata, exp_word));
            end
        end
    endtask

    task automatic finish_test(input string name);
        if (test_errs == 0) begin
            pass_count++;
            $display("Test %s: pass", name);
        end else begin
            fail_count++;
            $display("Test %s: fail with %0d errors", name, test_errs);
        end
        test_errs = 0;
    endtask

    initial begin
        tag_t    rt;
        index_t  rs;
        offset_t ro;
        int      rl;
        req        = 1'b0;
        addr       = '0;
        mem_valid  = 1'b0;
        mem_line   = '0;
        lfsr_state = 16'd24;
        m_time     = 0;
        test_errs  = 0;
        pass_count = 0;
        fail_count = 0;
        for (int s = 0; s < LINE_NUM; s++) begin
            for (int w = 0; w < WAY_NUM; w++) begin
                m_tag[s][w]   = '0;
                m_valid[s][w] = 1'b0;
                m_stamp[s][w] = 0;
            end
        end
        @(posedge rst_n);
        @(negedge clk);

        if (rdata_valid || mem_req || busy) begin
            report_error("outputs not idle after reset");
        end
        check_read(16'h1230, 3, WANT_MISS, 1'b0, '0);
        check_read(16'h4A74, 5, WANT_MISS, 1'b0, '0);
        check_read(16'hF00C, 1, WANT_MISS, 1'b0, '0);
        check_read(16'h0008, 8, WANT_MISS, 1'b0, '0);
        finish_test("first reads miss");

        check_read(16'h7B58, 2, WANT_MISS, 1'b0, '0);
        check_read(16'h7B5A, 2, WANT_HIT, 1'b0, '0);   // Same word, other byte
        check_read(16'h7B50, 2, WANT_HIT, 1'b0, '0);
        check_read(16'h7B54, 2, WANT_HIT, 1'b0, '0);
        check_read(16'h7B5C, 2, WANT_HIT, 1'b0, '0);
        check_read(16'h1230, 2, WANT_HIT, 1'b0, '0);
        finish_test("repeat and same line hits");

        check_read(make_addr(8'h21, 4'hB, 2'd0), 2, WANT_MISS, 1'b0, '0);
        check_read(make_addr(8'h42, 4'hB, 2'd1), 4, WANT_MISS, 1'b0, '0);
        check_read(make_addr(8'h63, 4'hB, 2'd2), 1, WANT_MISS, 1'b0, '0);
        check_read(make_addr(8'h84, 4'hB, 2'd3), 6, WANT_MISS, 1'b0, '0);
        check_read(make_addr(8'h63, 4'hB, 2'd0), 2, WANT_HIT, 1'b0, '0);
        check_read(make_addr(8'h21, 4'hB, 2'd1), 2, WANT_HIT, 1'b0, '0);
        check_read(make_addr(8'h84, 4'hB, 2'd2), 2, WANT_HIT, 1'b0, '0);
        check_read(make_addr(8'h42, 4'hB, 2'd3), 2, WANT_HIT, 1'b0, '0);
        check_read(make_addr(8'hA5, 4'hB, 2'd0), 3, WANT_MISS, 1'b0, '0);
        check_read(make_addr(8'h63, 4'hB, 2'd1), 2, WANT_MISS, 1'b0, '0);
        check_read(make_addr(8'h84, 4'hB, 2'd0), 2, WANT_HIT, 1'b0, '0);
        finish_test("LRU eviction");

        for (int i = 0; i < N_RANDOM; i++) begin
            rt = tag_t'(48 + 17 * take_bits(3));   // Eight tags over four ways
            rs = index_t'(take_bits(3));
            ro = offset_t'(take_bits(2));
            rl = 1 + take_bits(3);
            check_read(make_addr(rt, rs, ro), rl, WANT_ANY, 1'b0, '0);
        end
        finish_test("random reads");

        check_read(16'hC3E0, 4, WANT_MISS, 1'b1, 16'hD3E4);
        check_read(16'hC3E4, 2, WANT_HIT, 1'b1, 16'hD3E8);
        check_read(16'hD3E0, 2, WANT_MISS, 1'b0, '0);   // Would hit if a poke was taken
        check_read(16'hC3EC, 2, WANT_HIT, 1'b0, '0);
        finish_test("req while busy");

        $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- filelist.f
cache_pkg.sv
refill_if.sv
lru.sv
tag_ram.sv
data_ram.sv
cache_ctrl.sv
cache_top.sv
tb_clock_gen.sv
cache_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the cache testbench with Verilator and runs it

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module cache_tb \
    -f filelist.f -o cache_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/cache_sim > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation FAILED" "$SIM_LOG"; then
    exit 1
fi
if ! grep -q "Simulation PASSED" "$SIM_LOG"; then
    echo "No result line found in $SIM_LOG"
    exit 1
fi
exit 0
